// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pipe_ctrl
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

    //////////////////////////////
    // instruction fields
    //////////////////////////////

    // raw opcode as it comes out of the instruction register
    typedef logic [5:0] opcode_t;

    // alu function select, taken straight from the opcode
    typedef logic [3:0] alu_op_t;

    // position of the alu field inside the opcode
    localparam int unsigned ALU_OP_MSB = 4;
    localparam int unsigned ALU_OP_LSB = 1;

    // set on an alu opcode when an immediate word follows
    localparam int unsigned IMM_BIT = 0;

    // class boundaries, opcodes below JUMP_BASE are alu
    localparam opcode_t JUMP_BASE    = 6'd32;
    localparam opcode_t ILLEGAL_BASE = 6'd48;

    //////////////////////////////
    // decoded class
    //////////////////////////////

    typedef enum logic [1:0] {
        OPC_ALU     = 2'd0,
        OPC_JUMP    = 2'd1,
        OPC_ILLEGAL = 2'd2
    } op_class_t;

    //////////////////////////////
    // stage commands
    //////////////////////////////

    // memory stage, sampled once per dispatch
    typedef enum logic [1:0] {
        MEM_NONE     = 2'd0,
        MEM_LOAD     = 2'd1,
        MEM_STORE    = 2'd2,
        MEM_PORT_OUT = 2'd3
    } mem_cmd_t;

    // write-back stage, sampled once per dispatch
    typedef enum logic [1:0] {
        WB_NONE  = 2'd0,
        WB_MEM   = 2'd1,
        WB_ALU   = 2'd2,
        WB_FLAGS = 2'd3
    } wb_cmd_t;

endpackage

// ==== flist.f ====
ctrl_pkg.sv
issue_seq.sv
mem_seq.sv
wb_seq.sv
pipe_ctrl.sv
tb_clk_gen.sv
tb_pipe_ctrl.sv

// ==== issue_seq.sv ====
`timescale 1ns/1ps

module issue_seq
    import ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  opcode_t   opcode,
    input  logic      pc_w,
    input  logic      i_odv,
    input  logic      wb_idle,
    output logic      issue_idle,
    output logic      imem_rd,
    output logic      ir_load,
    output logic      opnd_load,
    output logic      pc_inc,
    output logic      pc_load,
    output logic      alu_en,
    output alu_op_t   alu_op,
    output logic      jmp_en,
    output logic      illegal
);

    typedef enum logic [2:0] {
        S_IDLE     = 3'd0,
        S_REDIRECT = 3'd1,
        S_FETCH    = 3'd2,
        S_DECODE   = 3'd3,
        S_EXECUTE  = 3'd4,
        S_OPERAND  = 3'd5,
        S_CAPTURE  = 3'd6
    } state_t;

    state_t    state;
    state_t    state_nxt;
    op_class_t op_class;
    logic      need_opnd;

    //////////////////////////////
    // opcode classification
    //////////////////////////////

    always_comb
    begin
        if (opcode >= ILLEGAL_BASE)
            op_class = OPC_ILLEGAL;
        else if (opcode >= JUMP_BASE)
            op_class = OPC_JUMP;
        else
            op_class = OPC_ALU;
    end

    // jumps always carry a target word, alu ops only with an immediate
    assign need_opnd = (op_class == OPC_JUMP) ||
                       ((op_class == OPC_ALU) && opcode[IMM_BIT]);

    //////////////////////////////
    // state register
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:
            begin
                // wait until write-back has drained
                if (wb_idle)
                    state_nxt = pc_w ? S_REDIRECT : S_FETCH;
            end
            S_REDIRECT: state_nxt = S_FETCH;
            S_FETCH:
            begin
                if (i_odv)
                    state_nxt = S_DECODE;
            end
            S_DECODE:   state_nxt = S_EXECUTE;
            S_EXECUTE:  state_nxt = need_opnd ? S_OPERAND : S_IDLE;
            S_OPERAND:
            begin
                if (i_odv)
                    state_nxt = S_CAPTURE;
            end
            S_CAPTURE:  state_nxt = S_IDLE;
            default:    state_nxt = S_IDLE;
        endcase
    end

    //////////////////////////////
    // control strobes
    //////////////////////////////

    assign issue_idle = (state == S_IDLE);
    assign imem_rd    = (state == S_FETCH) || (state == S_OPERAND);
    assign pc_load    = (state == S_REDIRECT);
    assign ir_load    = (state == S_DECODE);
    assign opnd_load  = (state == S_CAPTURE);
    // pc steps past the instruction word and again past the operand word
    assign pc_inc     = (state == S_DECODE) || (state == S_CAPTURE);

    always_comb
    begin
        alu_en  = 1'b0;
        alu_op  = '0;
        jmp_en  = 1'b0;
        illegal = 1'b0;
        if (state == S_EXECUTE)
        begin
            case (op_class)
                OPC_ALU:
                begin
                    alu_en = 1'b1;
                    alu_op = opcode[ALU_OP_MSB:ALU_OP_LSB];
                end
                OPC_JUMP: jmp_en  = 1'b1;
                default:  illegal = 1'b1;
            endcase
        end
    end

endmodule

// ==== mem_seq.sv ====
`timescale 1ns/1ps

module mem_seq
    import ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issue_idle,
    input  mem_cmd_t mem_cmd,
    input  logic     d_rdy,
    input  logic     d_odv,
    input  logic     hs_in,
    output logic     mem_idle,
    output logic     dmem_rd,
    output logic     dmem_wr,
    output logic     hs_out
);

    typedef enum logic [2:0] {
        S_IDLE     = 3'd0,
        S_DISPATCH = 3'd1,
        S_LD_READY = 3'd2,
        S_LD_XFER  = 3'd3,
        S_ST_READY = 3'd4,
        S_ST_XFER  = 3'd5,
        S_PO_WAIT  = 3'd6,
        S_PO_HOLD  = 3'd7
    } state_t;

    state_t state;
    state_t state_nxt;

    //////////////////////////////
    // state register
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:
            begin
                if (issue_idle)
                    state_nxt = S_DISPATCH;
            end
            S_DISPATCH:
            begin
                case (mem_cmd)
                    MEM_LOAD:     state_nxt = S_LD_READY;
                    MEM_STORE:    state_nxt = S_ST_READY;
                    MEM_PORT_OUT: state_nxt = S_PO_WAIT;
                    default:      state_nxt = S_IDLE;
                endcase
            end
            // stall here while write-back still owns the data path
            S_LD_READY:
            begin
                if (d_rdy)
                    state_nxt = S_LD_XFER;
            end
            S_LD_XFER:
            begin
                if (d_odv)
                    state_nxt = S_IDLE;
            end
            S_ST_READY:
            begin
                if (d_rdy)
                    state_nxt = S_ST_XFER;
            end
            S_ST_XFER:
            begin
                if (d_odv)
                    state_nxt = S_IDLE;
            end
            // port-out, first phase waits for the peer to ask
            S_PO_WAIT:
            begin
                if (hs_in)
                    state_nxt = S_PO_HOLD;
            end
            // second phase holds until the peer lets go
            S_PO_HOLD:
            begin
                if (!hs_in)
                    state_nxt = S_IDLE;
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    assign mem_idle = (state == S_IDLE);
    assign dmem_rd  = (state == S_LD_XFER);
    assign dmem_wr  = (state == S_ST_XFER);
    assign hs_out   = (state == S_PO_HOLD);

endmodule

// ==== pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl
    import ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // datapath status
    input  opcode_t  opcode,
    input  logic     pc_w,
    input  logic     i_odv,
    input  logic     d_odv,
    input  logic     hs_in,
    input  mem_cmd_t mem_cmd,
    input  wb_cmd_t  wb_cmd,
    // issue strobes
    output logic     imem_rd,
    output logic     ir_load,
    output logic     opnd_load,
    output logic     pc_inc,
    output logic     pc_load,
    output logic     alu_en,
    output alu_op_t  alu_op,
    output logic     jmp_en,
    output logic     illegal,
    // memory strobes
    output logic     dmem_rd,
    output logic     dmem_wr,
    output logic     hs_out,
    // write-back strobes
    output logic     reg_we,
    output logic     flag_we
);

    // stage-to-stage levels
    logic issue_idle;
    logic mem_idle;
    logic wb_idle;
    logic d_rdy;

    //////////////////////////////
    // issue stage
    //////////////////////////////

    issue_seq u_issue (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .pc_w       (pc_w),
        .i_odv      (i_odv),
        .wb_idle    (wb_idle),
        .issue_idle (issue_idle),
        .imem_rd    (imem_rd),
        .ir_load    (ir_load),
        .opnd_load  (opnd_load),
        .pc_inc     (pc_inc),
        .pc_load    (pc_load),
        .alu_en     (alu_en),
        .alu_op     (alu_op),
        .jmp_en     (jmp_en),
        .illegal    (illegal)
    );

    //////////////////////////////
    // memory stage
    //////////////////////////////

    mem_seq u_mem (
        .clk        (clk),
        .rst        (rst),
        .issue_idle (issue_idle),
        .mem_cmd    (mem_cmd),
        .d_rdy      (d_rdy),
        .d_odv      (d_odv),
        .hs_in      (hs_in),
        .mem_idle   (mem_idle),
        .dmem_rd    (dmem_rd),
        .dmem_wr    (dmem_wr),
        .hs_out     (hs_out)
    );

    //////////////////////////////
    // write-back stage
    //////////////////////////////

    wb_seq u_wb (
        .clk      (clk),
        .rst      (rst),
        .mem_idle (mem_idle),
        .wb_cmd   (wb_cmd),
        .d_odv    (d_odv),
        .wb_idle  (wb_idle),
        .d_rdy    (d_rdy),
        .reg_we   (reg_we),
        .flag_we  (flag_we)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic clk
);

    // 100 ns period, first rising edge at 50 ns
    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

endmodule

// ==== tb_pipe_ctrl.sv ====
`timescale 1ns/1ps

module tb_pipe_ctrl
    import ctrl_pkg::*;
();

    localparam int          NUM_CYCLES   = 4000;
    localparam int          RESET_CYCLES = 8;
    localparam int          WAIT_LIMIT   = 64;
    localparam logic [31:0] SEED         = 32'h5b7d_a4c1;

    // idle and dispatch take the lowest codes so drained() can compare
    localparam int I_IDLE     = 0;
    localparam int I_REDIRECT = 1;
    localparam int I_FETCH    = 2;
    localparam int I_DECODE   = 3;
    localparam int I_EXECUTE  = 4;
    localparam int I_OPERAND  = 5;
    localparam int I_CAPTURE  = 6;
    localparam int M_IDLE     = 0;
    localparam int M_DISPATCH = 1;
    localparam int M_LD_READY = 2;
    localparam int M_LD_XFER  = 3;
    localparam int M_ST_READY = 4;
    localparam int M_ST_XFER  = 5;
    localparam int M_PO_WAIT  = 6;
    localparam int M_PO_HOLD  = 7;
    localparam int W_IDLE     = 0;
    localparam int W_DISPATCH = 1;
    localparam int W_ALU_WR   = 2;
    localparam int W_FLAG_WR  = 3;
    localparam int W_MEM_WAIT = 4;

    logic     clk;
    logic     rst;
    opcode_t  opcode;
    logic     pc_w;
    logic     i_odv;
    logic     d_odv;
    logic     hs_in;
    mem_cmd_t mem_cmd;
    wb_cmd_t  wb_cmd;
    logic     imem_rd;
    logic     ir_load;
    logic     opnd_load;
    logic     pc_inc;
    logic     pc_load;
    logic     alu_en;
    alu_op_t  alu_op;
    logic     jmp_en;
    logic     illegal;
    logic     dmem_rd;
    logic     dmem_wr;
    logic     hs_out;
    logic     reg_we;
    logic     flag_we;

    int          is_st;
    int          ms_st;
    int          ws_st;
    logic [31:0] seed;
    logic        fetch_hit;
    int          checks;
    int          value_errors;
    int          rule_errors;
    int          timeouts;
    int          seen [10];
    string       strobe_names [10] = '{"alu_en", "jmp_en", "illegal", "opnd_load",
        "pc_load", "dmem_rd", "dmem_wr", "hs_out", "reg_we", "flag_we"};

    tb_clk_gen u_clk (.clk(clk));

    pipe_ctrl u_dut (.*);

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // class boundaries at 32 and 48
    function automatic op_class_t class_of(input opcode_t op);
        if (op >= ILLEGAL_BASE)
            return OPC_ILLEGAL;
        if (op >= JUMP_BASE)
            return OPC_JUMP;
        return OPC_ALU;
    endfunction

    function automatic logic drained();
        return (ms_st <= M_DISPATCH) && (ws_st <= W_DISPATCH);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected %0h actual %0h at %0t", name, expected, actual, $time);
            value_errors++;
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    // steps all three stages from their pre-edge states
    task automatic advance_model();
        int   is_nxt;
        int   ms_nxt;
        int   ws_nxt;
        logic cls_opnd;
        is_nxt = is_st;
        ms_nxt = ms_st;
        ws_nxt = ws_st;
        cls_opnd = (class_of(opcode) == OPC_JUMP) ||
                   (class_of(opcode) == OPC_ALU && opcode[IMM_BIT]);
        case (is_st)
            I_IDLE:
                if (ws_st == W_IDLE)
                    is_nxt = pc_w ? I_REDIRECT : I_FETCH;
            I_REDIRECT: is_nxt = I_FETCH;
            I_FETCH:    is_nxt = i_odv ? I_DECODE : I_FETCH;
            I_DECODE:   is_nxt = I_EXECUTE;
            I_EXECUTE:  is_nxt = cls_opnd ? I_OPERAND : I_IDLE;
            I_OPERAND:  is_nxt = i_odv ? I_CAPTURE : I_OPERAND;
            default:    is_nxt = I_IDLE;
        endcase
        case (ms_st)
            M_IDLE:     ms_nxt = (is_st == I_IDLE) ? M_DISPATCH : M_IDLE;
            M_DISPATCH:
                case (mem_cmd)
                    MEM_LOAD:     ms_nxt = M_LD_READY;
                    MEM_STORE:    ms_nxt = M_ST_READY;
                    MEM_PORT_OUT: ms_nxt = M_PO_WAIT;
                    default:      ms_nxt = M_IDLE;
                endcase
            // ready waits stall while write-back holds a memory result
            M_LD_READY: ms_nxt = (ws_st != W_MEM_WAIT) ? M_LD_XFER : M_LD_READY;
            M_ST_READY: ms_nxt = (ws_st != W_MEM_WAIT) ? M_ST_XFER : M_ST_READY;
            M_LD_XFER:  ms_nxt = d_odv ? M_IDLE : M_LD_XFER;
            M_ST_XFER:  ms_nxt = d_odv ? M_IDLE : M_ST_XFER;
            M_PO_WAIT:  ms_nxt = hs_in ? M_PO_HOLD : M_PO_WAIT;
            default:    ms_nxt = hs_in ? M_PO_HOLD : M_IDLE;
        endcase
        case (ws_st)
            W_IDLE:     ws_nxt = (ms_st == M_IDLE) ? W_DISPATCH : W_IDLE;
            W_DISPATCH:
                case (wb_cmd)
                    WB_MEM:   ws_nxt = W_MEM_WAIT;
                    WB_ALU:   ws_nxt = W_ALU_WR;
                    WB_FLAGS: ws_nxt = W_FLAG_WR;
                    default:  ws_nxt = W_IDLE;
                endcase
            W_MEM_WAIT: ws_nxt = d_odv ? W_IDLE : W_MEM_WAIT;
            default:    ws_nxt = W_IDLE;
        endcase
        is_st = rst ? I_IDLE : is_nxt;
        ms_st = rst ? M_IDLE : ms_nxt;
        ws_st = rst ? W_IDLE : ws_nxt;
    endtask

    task automatic check_outputs();
        logic      exec;
        op_class_t cls;
        exec = (is_st == I_EXECUTE);
        cls = class_of(opcode);
        check_value("imem_rd", 32'(is_st == I_FETCH || is_st == I_OPERAND), 32'(imem_rd));
        check_value("pc_load", 32'(is_st == I_REDIRECT), 32'(pc_load));
        check_value("ir_load", 32'(is_st == I_DECODE), 32'(ir_load));
        check_value("opnd_load", 32'(is_st == I_CAPTURE), 32'(opnd_load));
        check_value("pc_inc", 32'(is_st == I_DECODE || is_st == I_CAPTURE), 32'(pc_inc));
        check_value("alu_en", 32'(exec && cls == OPC_ALU), 32'(alu_en));
        check_value("alu_op", 32'((exec && cls == OPC_ALU) ? opcode[4:1] : 4'd0), 32'(alu_op));
        check_value("jmp_en", 32'(exec && cls == OPC_JUMP), 32'(jmp_en));
        check_value("illegal", 32'(exec && cls == OPC_ILLEGAL), 32'(illegal));
        check_value("dmem_rd", 32'(ms_st == M_LD_XFER), 32'(dmem_rd));
        check_value("dmem_wr", 32'(ms_st == M_ST_XFER), 32'(dmem_wr));
        check_value("hs_out", 32'(ms_st == M_PO_HOLD), 32'(hs_out));
        check_value("reg_we", 32'(ws_st == W_ALU_WR || ws_st == W_MEM_WAIT), 32'(reg_we));
        check_value("flag_we", 32'(ws_st == W_FLAG_WR), 32'(flag_we));
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic drive_inputs(input logic quiet);
        logic [31:0] r;
        logic [31:0] r_op;
        r = next_random();
        r_op = next_random();
        // opcode stays put through decode and execute
        if (is_st != I_DECODE && is_st != I_EXECUTE)
            opcode = r_op[31:26];
        if (quiet)
        begin
            pc_w = 1'b0;
            i_odv = 1'b1;
            d_odv = 1'b1;
            hs_in = !hs_out;
            mem_cmd = MEM_NONE;
            wb_cmd = WB_NONE;
        end
        else
        begin
            pc_w = (r[31:29] == 3'd0);
            i_odv = r[28];
            d_odv = r[27];
            mem_cmd = mem_cmd_t'(r[26:25]);
            wb_cmd = wb_cmd_t'(r[24:23]);
            // port peer raises and later drops its handshake
            if (hs_in)
                hs_in = (r[22:21] != 2'd0);
            else
                hs_in = (r[20:19] == 2'd0);
        end
    endtask

    task automatic step_cycle(input logic quiet);
        logic [9:0] strobes;
        @(negedge clk);
        advance_model();
        check_outputs();
        check_value("load after imem hit", 32'(fetch_hit), 32'(ir_load || opnd_load));
        if (ws_st == W_MEM_WAIT && (dmem_rd || dmem_wr))
        begin
            $display("memory transfer active while write-back waits at %0t", $time);
            rule_errors++;
        end
        strobes = {flag_we, reg_we, hs_out, dmem_wr, dmem_rd, pc_load, opnd_load,
                   illegal, jmp_en, alu_en};
        for (int i = 0; i < 10; i++)
            if (strobes[i])
                seen[i]++;
        drive_inputs(quiet);
        // an instruction word arrives while the model is fetching
        fetch_hit = (is_st == I_FETCH || is_st == I_OPERAND) && i_odv;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        int n;
        seed = SEED;
        rst = 1'b1;
        opcode = '0;
        pc_w = 1'b0;
        i_odv = 1'b0;
        d_odv = 1'b0;
        hs_in = 1'b0;
        mem_cmd = MEM_NONE;
        wb_cmd = WB_NONE;
        is_st = I_IDLE;
        ms_st = M_IDLE;
        ws_st = W_IDLE;
        fetch_hit = 1'b0;
        checks = 0;
        value_errors = 0;
        rule_errors = 0;
        timeouts = 0;
        for (int i = 0; i < 10; i++)
            seen[i] = 0;

        repeat (RESET_CYCLES)
            step_cycle(1'b0);
        rst = 1'b0;

        n = 0;
        while (!imem_rd && n < WAIT_LIMIT)
        begin
            step_cycle(1'b0);
            n++;
        end
        if (!imem_rd)
        begin
            $display("timeout: no instruction fetch started after reset");
            timeouts++;
        end

        repeat (NUM_CYCLES)
            step_cycle(1'b0);

        // quiet inputs let memory and write-back settle
        n = 0;
        while (!drained() && n < WAIT_LIMIT)
        begin
            step_cycle(1'b1);
            n++;
        end
        if (!drained())
        begin
            $display("timeout: memory and write-back stages did not drain");
            timeouts++;
        end

        for (int i = 0; i < 10; i++)
        begin
            if (seen[i] == 0)
            begin
                $display("strobe %s never went high during the run", strobe_names[i]);
                rule_errors++;
            end
        end

        $display("checks %0d, value errors %0d, rule errors %0d, timeouts %0d",
                 checks, value_errors, rule_errors, timeouts);
        if (value_errors + rule_errors + timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== wb_seq.sv ====
`timescale 1ns/1ps

module wb_seq
    import ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    mem_idle,
    input  wb_cmd_t wb_cmd,
    input  logic    d_odv,
    output logic    wb_idle,
    output logic    d_rdy,
    output logic    reg_we,
    output logic    flag_we
);

    typedef enum logic [2:0] {
        S_IDLE     = 3'd0,
        S_DISPATCH = 3'd1,
        S_ALU_WR   = 3'd2,
        S_FLAG_WR  = 3'd3,
        S_MEM_WAIT = 3'd4
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:
            begin
                if (mem_idle)
                    state_nxt = S_DISPATCH;
            end
            S_DISPATCH:
            begin
                case (wb_cmd)
                    WB_MEM:   state_nxt = S_MEM_WAIT;
                    WB_ALU:   state_nxt = S_ALU_WR;
                    WB_FLAGS: state_nxt = S_FLAG_WR;
                    default:  state_nxt = S_IDLE;
                endcase
            end
            S_ALU_WR:  state_nxt = S_IDLE;
            S_FLAG_WR: state_nxt = S_IDLE;
            S_MEM_WAIT:
            begin
                if (d_odv)
                    state_nxt = S_IDLE;
            end
            default:   state_nxt = S_IDLE;
        endcase
    end

    assign wb_idle = (state == S_IDLE);
    // memory result still outstanding, keep the memory stage off the bus
    assign d_rdy   = (state != S_MEM_WAIT);
    assign reg_we  = (state == S_ALU_WR) || (state == S_MEM_WAIT);
    assign flag_we = (state == S_FLAG_WR);

endmodule
